//--- id_branch_unit.sv
module id_branch_unit import id_pkg::*; (
    id_dec_if.consumer dec,
    input  word_t      pc,
    input  word_t      rj_value,
    input  word_t      rkd_value,
    output logic       cond_taken,
    output word_t      br_target
);
    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    // raw decision, not yet qualified by valid
    assign cond_taken = (dec.is_beq  &  eq)
                      | (dec.is_bne  & ~eq)
                      | (dec.is_blt  &  lt_s)
                      | (dec.is_bge  & ~lt_s)
                      | (dec.is_bltu &  lt_u)
                      | (dec.is_bgeu & ~lt_u)
                      | dec.is_jump;

    assign br_target = (dec.is_jirl ? rj_value : pc) + dec.br_offs;
endmodule

//--- id_decoder.sv
module id_decoder import id_pkg::*; (
    input  word_t      inst,
    id_dec_if.producer dec,
    output alu_op_t    alu_op,
    output reg_addr_t  dest,
    output logic       gr_we,
    output logic       mem_we,
    output logic       res_from_mem
);
    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        arith, reg3, shift_i;
    logic        i_add, i_sub, i_slt, i_sltu, i_nor, i_and, i_or, i_xor;
    logic        i_sll, i_srl, i_sra, i_slli, i_srli, i_srai;
    logic        i_addi, i_slti, i_sltui, i_andi, i_ori, i_xori;
    logic        i_lu12i, i_pcaddu12i, i_ld_w, i_st_w;
    logic        i_jirl, i_b, i_bl, cond_br;
    logic        need_ui5, need_si12, need_si20, need_ui12, src2_is_4;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};   // offs[25:16] sits in the low bits

    assign arith   = (op6 == OP6_ARITH);
    assign reg3    = arith && (op4 == OP4_REG) && (op2 == OP2_REG3);
    assign shift_i = arith && (op4 == OP4_SHIFT_I) && (op2 == OP2_SHIFT_I);

    assign i_add  = reg3 && (op5 == OP5_ADD_W);
    assign i_sub  = reg3 && (op5 == OP5_SUB_W);
    assign i_slt  = reg3 && (op5 == OP5_SLT);
    assign i_sltu = reg3 && (op5 == OP5_SLTU);
    assign i_nor  = reg3 && (op5 == OP5_NOR);
    assign i_and  = reg3 && (op5 == OP5_AND);
    assign i_or   = reg3 && (op5 == OP5_OR);
    assign i_xor  = reg3 && (op5 == OP5_XOR);
    assign i_sll  = reg3 && (op5 == OP5_SLL_W);
    assign i_srl  = reg3 && (op5 == OP5_SRL_W);
    assign i_sra  = reg3 && (op5 == OP5_SRA_W);
    assign i_slli = shift_i && (op5 == OP5_SLLI_W);
    assign i_srli = shift_i && (op5 == OP5_SRLI_W);
    assign i_srai = shift_i && (op5 == OP5_SRAI_W);

    assign i_addi  = arith && (op4 == OP4_ADDI_W);
    assign i_slti  = arith && (op4 == OP4_SLTI);
    assign i_sltui = arith && (op4 == OP4_SLTUI);
    assign i_andi  = arith && (op4 == OP4_ANDI);
    assign i_ori   = arith && (op4 == OP4_ORI);
    assign i_xori  = arith && (op4 == OP4_XORI);

    assign i_lu12i     = (op6 == OP6_LU12I) && !inst[25];
    assign i_pcaddu12i = (op6 == OP6_PCADDU12I) && !inst[25];
    assign i_ld_w      = (op6 == OP6_MEM) && (op4 == OP4_LD_W);
    assign i_st_w      = (op6 == OP6_MEM) && (op4 == OP4_ST_W);

    assign i_jirl = (op6 == OP6_JIRL);
    assign i_b    = (op6 == OP6_B);
    assign i_bl   = (op6 == OP6_BL);

    assign dec.is_beq  = (op6 == OP6_BEQ);
    assign dec.is_bne  = (op6 == OP6_BNE);
    assign dec.is_blt  = (op6 == OP6_BLT);
    assign dec.is_bge  = (op6 == OP6_BGE);
    assign dec.is_bltu = (op6 == OP6_BLTU);
    assign dec.is_bgeu = (op6 == OP6_BGEU);
    assign dec.is_jump = i_b | i_bl | i_jirl;
    assign dec.is_jirl = i_jirl;
    assign cond_br = dec.is_beq | dec.is_bne | dec.is_blt | dec.is_bge
                   | dec.is_bltu | dec.is_bgeu;

    assign alu_op[ALU_ADD]  = i_add | i_addi | i_ld_w | i_st_w | i_jirl | i_bl | i_pcaddu12i;
    assign alu_op[ALU_SUB]  = i_sub;
    assign alu_op[ALU_SLT]  = i_slt | i_slti;
    assign alu_op[ALU_SLTU] = i_sltu | i_sltui;
    assign alu_op[ALU_AND]  = i_and | i_andi;
    assign alu_op[ALU_NOR]  = i_nor;
    assign alu_op[ALU_OR]   = i_or | i_ori;
    assign alu_op[ALU_XOR]  = i_xor | i_xori;
    assign alu_op[ALU_SLL]  = i_sll | i_slli;
    assign alu_op[ALU_SRL]  = i_srl | i_srli;
    assign alu_op[ALU_SRA]  = i_sra | i_srai;
    assign alu_op[ALU_LUI]  = i_lu12i;

    assign need_ui5  = i_slli | i_srli | i_srai;
    assign need_si12 = i_addi | i_ld_w | i_st_w | i_slti | i_sltui;
    assign need_si20 = i_lu12i | i_pcaddu12i;
    assign need_ui12 = i_andi | i_ori | i_xori;
    assign src2_is_4 = i_jirl | i_bl;   // link address

    assign dec.imm = src2_is_4 ? 32'd4                  :
                     need_si20 ? {i20, 12'b0}            :
                     need_ui5  ? {27'b0, rk}             :
                     need_si12 ? {{20{i12[11]}}, i12}    :
                     need_ui12 ? {20'b0, i12}            : 32'b0;

    assign dec.br_offs = (i_b | i_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                      : {{14{i16[15]}}, i16, 2'b0};

    assign dec.src1_is_pc  = i_jirl | i_bl | i_pcaddu12i;
    assign dec.src2_is_imm = src2_is_4 | need_si20 | need_ui5 | need_si12 | need_ui12;

    assign dec.raddr1 = rj;
    assign dec.raddr2 = (i_st_w | cond_br) ? rd : rk;
    assign dec.need1  = reg3 | shift_i | need_si12 | need_ui12 | cond_br | i_jirl;
    assign dec.need2  = reg3 | i_st_w | cond_br;

    assign dest         = i_bl ? 5'd1 : rd;
    assign gr_we        = ~i_st_w & ~cond_br & ~i_b;
    assign mem_we       = i_st_w;
    assign res_from_mem = i_ld_w;
endmodule

//--- id_ifs.sv
interface id_dec_if import id_pkg::*; ();
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      need1;       // rj really read
    logic      need2;       // rk/rd really read
    word_t     imm;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      is_beq;
    logic      is_bne;
    logic      is_blt;
    logic      is_bge;
    logic      is_bltu;
    logic      is_bgeu;
    logic      is_jump;     // b, bl, jirl
    logic      is_jirl;
    word_t     br_offs;

    modport producer (
        output raddr1, raddr2, need1, need2, imm, src1_is_pc, src2_is_imm,
               is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_jump, is_jirl,
               br_offs
    );

    modport consumer (
        input  raddr1, raddr2, need1, need2, imm, src1_is_pc, src2_is_imm,
               is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_jump, is_jirl,
               br_offs
    );
endinterface

// results coming back from later stages
interface id_fwd_if import id_pkg::*; ();
    logic      ex_valid;
    logic      ex_is_load;
    reg_addr_t ex_dest;
    word_t     ex_wdata;
    logic      mem_valid;
    reg_addr_t mem_dest;
    word_t     mem_wdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    modport sink (
        input ex_valid, ex_is_load, ex_dest, ex_wdata,
              mem_valid, mem_dest, mem_wdata,
              wb_we, wb_waddr, wb_wdata
    );
endinterface

//--- id_operand_bypass.sv
module id_operand_bypass import id_pkg::*; (
    id_dec_if.consumer dec,
    id_fwd_if.sink     fwd,
    input  word_t      rdata1,
    input  word_t      rdata2,
    input  word_t      pc,
    output word_t      rj_value,
    output word_t      rkd_value,
    output word_t      alu_src1,
    output word_t      alu_src2,
    output logic       ready_go
);
    logic ld_hit1;
    logic ld_hit2;

    // youngest producer wins
    function automatic word_t pick(input reg_addr_t addr, input logic need, input word_t rf_val);
        logic live;
        live = need && (addr != '0);
        if (live && fwd.ex_valid && (fwd.ex_dest == addr)) begin
            return fwd.ex_wdata;
        end
        if (live && fwd.mem_valid && (fwd.mem_dest == addr)) begin
            return fwd.mem_wdata;
        end
        if (live && fwd.wb_we && (fwd.wb_waddr == addr)) begin
            return fwd.wb_wdata;   // lands in the file on the next edge
        end
        return rf_val;
    endfunction

    assign rj_value  = pick(dec.raddr1, dec.need1, rdata1);
    assign rkd_value = pick(dec.raddr2, dec.need2, rdata2);

    assign alu_src1 = dec.src1_is_pc  ? pc      : rj_value;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_value;

    // load data not there until MEM
    assign ld_hit1 = dec.need1 && (dec.raddr1 != '0) && (fwd.ex_dest == dec.raddr1);
    assign ld_hit2 = dec.need2 && (dec.raddr2 != '0) && (fwd.ex_dest == dec.raddr2);
    assign ready_go = ~(fwd.ex_valid & fwd.ex_is_load & (ld_hit1 | ld_hit2));
endmodule

//--- id_pipe_ctrl.sv
module id_pipe_ctrl import id_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  logic  if_id_valid,
    input  word_t if_pc,
    input  word_t if_inst,
    input  logic  ex_allowin,
    input  logic  ready_go,
    input  logic  cond_taken,
    output logic  id_allowin,
    output logic  id_ex_valid,
    output logic  br_taken,
    output word_t inst,
    output word_t pc
);
    logic valid;

    assign id_ex_valid = valid & ready_go;
    assign id_allowin  = ~valid | (id_ex_valid & ex_allowin);
    assign br_taken    = id_ex_valid & cond_taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (br_taken && ex_allowin) begin
            valid <= 1'b0;   // drop the wrong-path fetch
        end else if (id_allowin) begin
            valid <= if_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_valid && id_allowin) begin
            pc   <= if_pc;
            inst <= if_inst;
        end
    end
endmodule

//--- id_pkg.sv
package id_pkg;

    localparam int WORD_W   = 32;
    localparam int REG_AW   = 5;
    localparam int ALU_OP_W = 12;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [REG_AW-1:0]   reg_addr_t;
    typedef logic [ALU_OP_W-1:0] alu_op_t;   // one-hot

    // bit positions inside alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // inst[31:26]
    localparam logic [5:0] OP6_ARITH     = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] OP4_REG     = 4'h0;
    localparam logic [3:0] OP4_SHIFT_I = 4'h1;
    localparam logic [3:0] OP4_LD_W    = 4'h2;
    localparam logic [3:0] OP4_ST_W    = 4'h6;
    localparam logic [3:0] OP4_SLTI    = 4'h8;
    localparam logic [3:0] OP4_SLTUI   = 4'h9;
    localparam logic [3:0] OP4_ADDI_W  = 4'ha;
    localparam logic [3:0] OP4_ANDI    = 4'hd;
    localparam logic [3:0] OP4_ORI     = 4'he;
    localparam logic [3:0] OP4_XORI    = 4'hf;

    // inst[21:20]
    localparam logic [1:0] OP2_REG3    = 2'h1;
    localparam logic [1:0] OP2_SHIFT_I = 2'h0;

    // inst[19:15]
    localparam logic [4:0] OP5_ADD_W  = 5'h00;
    localparam logic [4:0] OP5_SUB_W  = 5'h02;
    localparam logic [4:0] OP5_SLT    = 5'h04;
    localparam logic [4:0] OP5_SLTU   = 5'h05;
    localparam logic [4:0] OP5_NOR    = 5'h08;
    localparam logic [4:0] OP5_AND    = 5'h09;
    localparam logic [4:0] OP5_OR     = 5'h0a;
    localparam logic [4:0] OP5_XOR    = 5'h0b;
    localparam logic [4:0] OP5_SLL_W  = 5'h0e;
    localparam logic [4:0] OP5_SRL_W  = 5'h0f;
    localparam logic [4:0] OP5_SRA_W  = 5'h10;
    localparam logic [4:0] OP5_SLLI_W = 5'h01;
    localparam logic [4:0] OP5_SRLI_W = 5'h09;
    localparam logic [4:0] OP5_SRAI_W = 5'h11;

endpackage

//--- id_regfile.sv
module id_regfile import id_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);
    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, its array slot is never written
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

//--- id_stage.sv
module id_stage import id_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      if_id_valid,
    output logic      id_allowin,
    input  word_t     if_pc,
    input  word_t     if_inst,
    output logic      br_taken,
    output word_t     br_target,
    input  logic      ex_allowin,
    output logic      id_ex_valid,
    output alu_op_t   alu_op,
    output word_t     alu_src1,
    output word_t     alu_src2,
    output word_t     rkd_value,
    output word_t     id_pc,
    output reg_addr_t dest,
    output logic      gr_we,
    output logic      mem_we,
    output logic      res_from_mem,
    input  logic      ex_fwd_valid,
    input  logic      ex_is_load,
    input  reg_addr_t ex_dest,
    input  word_t     ex_wdata,
    input  logic      mem_fwd_valid,
    input  reg_addr_t mem_dest,
    input  word_t     mem_wdata,
    input  logic      wb_we,
    input  reg_addr_t wb_waddr,
    input  word_t     wb_wdata
);
    word_t id_inst;
    word_t rdata1;
    word_t rdata2;
    word_t rj_value;
    logic  ready_go;
    logic  cond_taken;

    id_dec_if dec_if ();
    id_fwd_if fwd_if ();

    assign fwd_if.ex_valid   = ex_fwd_valid;
    assign fwd_if.ex_is_load = ex_is_load;
    assign fwd_if.ex_dest    = ex_dest;
    assign fwd_if.ex_wdata   = ex_wdata;
    assign fwd_if.mem_valid  = mem_fwd_valid;
    assign fwd_if.mem_dest   = mem_dest;
    assign fwd_if.mem_wdata  = mem_wdata;
    assign fwd_if.wb_we      = wb_we;
    assign fwd_if.wb_waddr   = wb_waddr;
    assign fwd_if.wb_wdata   = wb_wdata;

    id_pipe_ctrl u_ctrl (
        .clk(clk), .resetn(resetn),
        .if_id_valid(if_id_valid), .if_pc(if_pc), .if_inst(if_inst),
        .ex_allowin(ex_allowin), .ready_go(ready_go), .cond_taken(cond_taken),
        .id_allowin(id_allowin), .id_ex_valid(id_ex_valid), .br_taken(br_taken),
        .inst(id_inst), .pc(id_pc)
    );

    id_decoder u_dec (
        .inst(id_inst), .dec(dec_if.producer),
        .alu_op(alu_op), .dest(dest), .gr_we(gr_we),
        .mem_we(mem_we), .res_from_mem(res_from_mem)
    );

    id_regfile #(.NUM_REGS(NUM_REGS)) u_rf (
        .clk(clk),
        .raddr1(dec_if.raddr1), .rdata1(rdata1),
        .raddr2(dec_if.raddr2), .rdata2(rdata2),
        .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata)
    );

    id_operand_bypass u_byp (
        .dec(dec_if.consumer), .fwd(fwd_if.sink),
        .rdata1(rdata1), .rdata2(rdata2), .pc(id_pc),
        .rj_value(rj_value), .rkd_value(rkd_value),
        .alu_src1(alu_src1), .alu_src2(alu_src2), .ready_go(ready_go)
    );

    id_branch_unit u_br (
        .dec(dec_if.consumer), .pc(id_pc),
        .rj_value(rj_value), .rkd_value(rkd_value),
        .cond_taken(cond_taken), .br_target(br_target)
    );
endmodule

//--- run.sh
#!/bin/sh
# build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_stage -f sources.f -o tb_id_stage_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_id_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** PASSED ***' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sources.f
id_pkg.sv
id_ifs.sv
id_regfile.sv
id_decoder.sv
id_operand_bypass.sv
id_branch_unit.sv
id_pipe_ctrl.sv
id_stage.sv
tb_clkgen.sv
tb_id_stage_sva.sv
tb_id_stage.sv

//--- tb_clkgen.sv
module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;   // released on a falling edge
    end
endmodule

//--- tb_id_stage.sv
module tb_id_stage import id_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS    = 8;
    localparam int CYCLE_NS     = 10;
    localparam int LIMIT_CYCLES = 200 * NUM_TESTS + 8;
    localparam int POLL_MAX     = 50;

    logic      clk;
    logic      resetn;
    logic      if_id_valid;
    logic      id_allowin;
    word_t     if_pc;
    word_t     if_inst;
    logic      br_taken;
    word_t     br_target;
    logic      ex_allowin;
    logic      id_ex_valid;
    alu_op_t   alu_op;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     rkd_value;
    word_t     id_pc;
    reg_addr_t dest;
    logic      gr_we;
    logic      mem_we;
    logic      res_from_mem;
    logic      ex_fwd_valid;
    logic      ex_is_load;
    reg_addr_t ex_dest;
    word_t     ex_wdata;
    logic      mem_fwd_valid;
    reg_addr_t mem_dest;
    word_t     mem_wdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    int errors;
    int tests_done;
    int tests_failed;

    tb_clkgen #(.PERIOD_NS(CYCLE_NS), .RESET_CYCLES(8)) clkgen0 (.clk(clk), .resetn(resetn));

    id_stage #(.NUM_REGS(32)) dut0 (.*);

    // instruction formats
    function automatic word_t three_reg(input logic [4:0] op5, input reg_addr_t rd,
                                        input reg_addr_t rj, input reg_addr_t rk);
        return {OP6_ARITH, OP4_REG, OP2_REG3, op5, rk, rj, rd};
    endfunction

    function automatic word_t reg_imm12(input logic [5:0] op6, input logic [3:0] op4,
                                        input reg_addr_t rd, input reg_addr_t rj,
                                        input logic [11:0] i12);
        return {op6, op4, i12, rj, rd};
    endfunction

    function automatic word_t shift_imm(input logic [4:0] op5, input reg_addr_t rd,
                                        input reg_addr_t rj, input logic [4:0] ui5);
        return {OP6_ARITH, OP4_SHIFT_I, OP2_SHIFT_I, op5, ui5, rj, rd};
    endfunction

    function automatic word_t upper_imm20(input logic [5:0] op6, input reg_addr_t rd,
                                          input logic [19:0] i20);
        return {op6, 1'b0, i20, rd};
    endfunction

    function automatic word_t branch16(input logic [5:0] op6, input reg_addr_t rd,
                                       input reg_addr_t rj, input logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    function automatic word_t jump26(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    function automatic alu_op_t op_bit(input int idx);
        alu_op_t v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    task automatic expect_eq(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_done++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - err_before);
        end
    endtask

    // idle the bypass ports and let the stage empty
    task automatic flush();
        int n;
        @(negedge clk);
        if_id_valid   = 1'b0;
        ex_allowin    = 1'b1;
        ex_fwd_valid  = 1'b0;
        ex_is_load    = 1'b0;
        mem_fwd_valid = 1'b0;
        wb_we         = 1'b0;
        n = 0;
        @(negedge clk);
        while (id_ex_valid && n < POLL_MAX) begin
            @(negedge clk);
            n++;
        end
        if (id_ex_valid) begin
            $display("flush: stage did not drain within %0d cycles", POLL_MAX);
            errors++;
        end
    endtask

    // returns just after a falling edge with the instruction in ID
    task automatic send(input word_t pc, input word_t inst);
        int n;
        n = 0;
        @(negedge clk);
        while (!id_allowin && n < POLL_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!id_allowin) begin
            $display("send: id_allowin stayed low, instruction %h not accepted", inst);
            errors++;
        end
        if_id_valid = 1'b1;
        if_pc       = pc;
        if_inst     = inst;
        @(negedge clk);
        if_id_valid = 1'b0;
        #2;
    endtask

    task automatic rf_write(input reg_addr_t addr, input word_t val);
        @(negedge clk);
        wb_we    = 1'b1;
        wb_waddr = addr;
        wb_wdata = val;
        @(negedge clk);
        wb_we = 1'b0;
    endtask

    task automatic check_ctrl(input string tag, input int op_idx, input word_t src2,
                              input reg_addr_t exp_dest, input logic exp_gr_we,
                              input logic exp_mem_we, input logic exp_res_from_mem);
        expect_eq({tag, " id_ex_valid"}, 32'(id_ex_valid), 32'd1);
        expect_eq({tag, " alu_op"}, 32'(alu_op), 32'(op_bit(op_idx)));
        expect_eq({tag, " alu_src2"}, alu_src2, src2);
        expect_eq({tag, " dest"}, 32'(dest), 32'(exp_dest));
        expect_eq({tag, " gr_we"}, 32'(gr_we), 32'(exp_gr_we));
        expect_eq({tag, " mem_we"}, 32'(mem_we), 32'(exp_mem_we));
        expect_eq({tag, " res_from_mem"}, 32'(res_from_mem), 32'(exp_res_from_mem));
    endtask

    task automatic reset_state();
        int e0;
        e0 = errors;
        @(negedge clk);
        #2;
        expect_eq("id_ex_valid", 32'(id_ex_valid), 32'd0);
        expect_eq("br_taken", 32'(br_taken), 32'd0);
        expect_eq("id_allowin", 32'(id_allowin), 32'd1);
        report_test("reset", e0);
    endtask

    task automatic regfile_rw();
        word_t v;
        word_t junk;
        int    e0;
        e0 = errors;
        v = $urandom();
        junk = $urandom() | 32'h1;   // nonzero write into r0
        flush();
        rf_write(5'd5, v);
        rf_write(5'd0, junk);
        send(32'h1c00_0000, three_reg(OP5_ADD_W, 5'd3, 5'd5, 5'd0));
        expect_eq("alu_src1 from r5", alu_src1, v);
        expect_eq("rkd_value from r0", rkd_value, 32'd0);
        send(32'h1c00_0004, three_reg(OP5_ADD_W, 5'd3, 5'd0, 5'd5));
        expect_eq("alu_src1 from r0", alu_src1, 32'd0);
        expect_eq("rkd_value from r5", rkd_value, v);
        report_test("regfile", e0);
    endtask

    task automatic alu_decode();
        word_t r6;
        int    e0;
        e0 = errors;
        r6 = $urandom();
        flush();
        rf_write(5'd6, r6);
        send(32'h1c00_0100, reg_imm12(OP6_ARITH, OP4_ADDI_W, 5'd4, 5'd2, 12'hffb));
        check_ctrl("addi.w", ALU_ADD, 32'hffff_fffb, 5'd4, 1'b1, 1'b0, 1'b0);
        expect_eq("addi.w id_pc", id_pc, 32'h1c00_0100);
        send(32'h1c00_0104, reg_imm12(OP6_ARITH, OP4_ORI, 5'd7, 5'd2, 12'h8f0));
        check_ctrl("ori", ALU_OR, 32'h0000_08f0, 5'd7, 1'b1, 1'b0, 1'b0);
        send(32'h1c00_0108, shift_imm(OP5_SLLI_W, 5'd8, 5'd2, 5'd13));
        check_ctrl("slli.w", ALU_SLL, 32'd13, 5'd8, 1'b1, 1'b0, 1'b0);
        send(32'h1c00_010c, upper_imm20(OP6_LU12I, 5'd9, 20'habcde));
        check_ctrl("lu12i.w", ALU_LUI, 32'habcd_e000, 5'd9, 1'b1, 1'b0, 1'b0);
        send(32'h1c00_0110, reg_imm12(OP6_MEM, OP4_ST_W, 5'd6, 5'd2, 12'h010));
        check_ctrl("st.w", ALU_ADD, 32'd16, 5'd6, 1'b0, 1'b1, 1'b0);
        expect_eq("st.w rkd_value", rkd_value, r6);
        send(32'h1c00_0114, reg_imm12(OP6_MEM, OP4_LD_W, 5'd13, 5'd6, 12'hffc));
        check_ctrl("ld.w", ALU_ADD, 32'hffff_fffc, 5'd13, 1'b1, 1'b0, 1'b1);
        report_test("alu_decode", e0);
    endtask

    task automatic forwarding();
        word_t ev;
        word_t mv;
        word_t wv;
        int    e0;
        e0 = errors;
        ev = $urandom();
        mv = $urandom();
        wv = $urandom();
        flush();
        ex_allowin    = 1'b0;   // hold the add in ID
        ex_fwd_valid  = 1'b1;
        ex_dest       = 5'd7;
        ex_wdata      = ev;
        mem_fwd_valid = 1'b1;
        mem_dest      = 5'd7;
        mem_wdata     = mv;
        wb_we         = 1'b1;
        wb_waddr      = 5'd7;
        wb_wdata      = wv;
        send(32'h1c00_0200, three_reg(OP5_ADD_W, 5'd8, 5'd7, 5'd0));
        expect_eq("alu_src1 via ex", alu_src1, ev);
        @(negedge clk);
        ex_fwd_valid = 1'b0;
        #2;
        expect_eq("alu_src1 via mem", alu_src1, mv);
        @(negedge clk);
        mem_fwd_valid = 1'b0;
        #2;
        expect_eq("alu_src1 via wb", alu_src1, wv);
        @(negedge clk);
        wb_we = 1'b0;
        #2;
        expect_eq("alu_src1 via regfile", alu_src1, wv);
        report_test("forwarding", e0);
    endtask

    task automatic load_use_stall();
        word_t ld;
        int    e0;
        e0 = errors;
        ld = $urandom();
        flush();
        ex_fwd_valid = 1'b1;
        ex_is_load   = 1'b1;
        ex_dest      = 5'd9;
        ex_wdata     = $urandom();   // not the load data yet
        send(32'h1c00_0300, three_reg(OP5_SUB_W, 5'd10, 5'd2, 5'd9));
        expect_eq("id_ex_valid on load-use", 32'(id_ex_valid), 32'd0);
        expect_eq("id_allowin on load-use", 32'(id_allowin), 32'd0);
        repeat (3) @(negedge clk);
        #2;
        expect_eq("id_ex_valid still stalled", 32'(id_ex_valid), 32'd0);
        expect_eq("id_allowin still stalled", 32'(id_allowin), 32'd0);
        @(negedge clk);
        ex_fwd_valid  = 1'b0;        // load moves on to MEM
        ex_is_load    = 1'b0;
        mem_fwd_valid = 1'b1;
        mem_dest      = 5'd9;
        mem_wdata     = ld;
        #2;
        expect_eq("id_ex_valid after release", 32'(id_ex_valid), 32'd1);
        expect_eq("rkd_value after release", rkd_value, ld);
        expect_eq("alu_src2 after release", alu_src2, ld);
        report_test("load_use", e0);
    endtask

    task automatic back_pressure();
        int e0;
        e0 = errors;
        flush();
        ex_allowin = 1'b0;
        send(32'h1c00_0400, reg_imm12(OP6_ARITH, OP4_ORI, 5'd11, 5'd3, 12'h0f0));
        @(negedge clk);
        if_id_valid = 1'b1;          // next one waits in IF
        if_pc       = 32'h1c00_0404;
        if_inst     = reg_imm12(OP6_ARITH, OP4_XORI, 5'd12, 5'd4, 12'h00f);
        repeat (3) @(negedge clk);
        #2;
        expect_eq("id_ex_valid held", 32'(id_ex_valid), 32'd1);
        expect_eq("id_allowin held", 32'(id_allowin), 32'd0);
        expect_eq("alu_op held", 32'(alu_op), 32'(op_bit(ALU_OR)));
        expect_eq("alu_src2 held", alu_src2, 32'h0000_00f0);
        expect_eq("dest held", 32'(dest), 32'd11);
        expect_eq("id_pc held", id_pc, 32'h1c00_0400);
        @(negedge clk);
        if_id_valid = 1'b0;
        ex_allowin  = 1'b1;
        report_test("back_pressure", e0);
    endtask

    task automatic branches();
        word_t a;
        word_t jr;
        int    e0;
        e0 = errors;
        a  = $urandom() | 32'h8000_0000;   // never equal to r13
        jr = $urandom();
        flush();
        rf_write(5'd10, a);
        rf_write(5'd11, a);
        rf_write(5'd12, 32'hffff_ffff);
        rf_write(5'd13, 32'd1);
        rf_write(5'd14, jr);
        send(32'h1c00_0500, branch16(OP6_BEQ, 5'd11, 5'd10, 16'h0010));
        expect_eq("beq equal br_taken", 32'(br_taken), 32'd1);
        expect_eq("beq br_target", br_target, 32'h1c00_0540);
        send(32'h1c00_0600, branch16(OP6_BEQ, 5'd13, 5'd10, 16'h0010));
        expect_eq("beq unequal br_taken", 32'(br_taken), 32'd0);
        send(32'h1c00_0700, branch16(OP6_BLT, 5'd13, 5'd12, 16'h0004));
        expect_eq("blt -1 < 1 br_taken", 32'(br_taken), 32'd1);
        send(32'h1c00_0704, branch16(OP6_BLTU, 5'd13, 5'd12, 16'h0004));
        expect_eq("bltu max < 1 br_taken", 32'(br_taken), 32'd0);
        send(32'h1c00_0800, jump26(OP6_BL, 26'h3ff_fff0));
        expect_eq("bl br_taken", 32'(br_taken), 32'd1);
        expect_eq("bl br_target", br_target, 32'h1c00_07c0);
        expect_eq("bl dest", 32'(dest), 32'd1);
        expect_eq("bl alu_src2", alu_src2, 32'd4);
        expect_eq("bl alu_src1", alu_src1, 32'h1c00_0800);
        send(32'h1c00_0900, branch16(OP6_JIRL, 5'd1, 5'd14, 16'h0008));
        expect_eq("jirl br_taken", 32'(br_taken), 32'd1);
        expect_eq("jirl br_target", br_target, jr + 32'h20);
        expect_eq("jirl alu_src2", alu_src2, 32'd4);
        report_test("branches", e0);
    endtask

    task automatic squash();
        int e0;
        e0 = errors;
        flush();
        @(negedge clk);
        if_id_valid = 1'b1;
        if_pc       = 32'h1c00_0a00;
        if_inst     = branch16(OP6_BEQ, 5'd0, 5'd0, 16'h0004);   // r0 == r0
        @(negedge clk);
        if_pc   = 32'h1c00_0a04;     // wrong-path add offered while beq resolves
        if_inst = three_reg(OP5_ADD_W, 5'd3, 5'd2, 5'd2);
        #2;
        expect_eq("squash br_taken", 32'(br_taken), 32'd1);
        expect_eq("squash br_target", br_target, 32'h1c00_0a10);
        @(negedge clk);
        if_id_valid = 1'b0;
        repeat (3) begin
            #2;
            expect_eq("id_ex_valid after squash", 32'(id_ex_valid), 32'd0);
            @(negedge clk);
        end
        report_test("squash", e0);
    endtask

    initial begin
        errors        = 0;
        tests_done    = 0;
        tests_failed  = 0;
        if_id_valid   = 1'b0;
        if_pc         = '0;
        if_inst       = '0;
        ex_allowin    = 1'b1;
        ex_fwd_valid  = 1'b0;
        ex_is_load    = 1'b0;
        ex_dest       = '0;
        ex_wdata      = '0;
        mem_fwd_valid = 1'b0;
        mem_dest      = '0;
        mem_wdata     = '0;
        wb_we         = 1'b0;
        wb_waddr      = '0;
        wb_wdata      = '0;
        void'($urandom(32'h8f8f_d1c7));
        wait (resetn === 1'b1);
        reset_state();
        regfile_rw();
        alu_decode();
        forwarding();
        load_use_stall();
        back_pressure();
        branches();
        squash();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT_CYCLES * CYCLE_NS);
        $display("watchdog: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end
endmodule

//--- tb_id_stage_sva.sv
module tb_id_stage_sva (
    input logic clk,
    input logic resetn,
    input logic if_id_valid,
    input logic id_allowin,
    input logic ex_allowin,
    input logic id_ex_valid,
    input logic br_taken
);
    timeunit 1ns;
    timeprecision 1ps;

    logic held;   // occupancy rebuilt from the handshake

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held <= 1'b0;
        end else if (br_taken && ex_allowin) begin
            held <= 1'b0;   // wrong-path fetch dropped with the branch
        end else if (if_id_valid && id_allowin) begin
            held <= 1'b1;
        end else if (id_ex_valid && ex_allowin) begin
            held <= 1'b0;
        end
    end

    a_issue_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        id_ex_valid |-> held)
        else $error("id_ex_valid high while the stage holds no instruction");

    a_taken_needs_issue: assert property (@(posedge clk) disable iff (!resetn)
        br_taken |-> id_ex_valid && held)
        else $error("br_taken high without an issuing instruction");

    // first cycle out of reset
    a_allowin_after_reset: assert property (@(posedge clk)
        $rose(resetn) |-> id_allowin)
        else $error("id_allowin low right after reset");
endmodule

bind id_stage tb_id_stage_sva sva0 (
    .clk(clk), .resetn(resetn), .if_id_valid(if_id_valid), .id_allowin(id_allowin),
    .ex_allowin(ex_allowin), .id_ex_valid(id_ex_valid), .br_taken(br_taken)
);
